// ==== sim.f ====
+incdir+include
source/mem_arb_pkg.sv
source/mem_fifo_reg.sv
source/icache_line_upsize.sv
source/mem_read_arbiter.sv
source/mem_resp_demux.sv
source/mem_to_axi_read.sv
source/mem_read_subsystem.sv
dv/mem_read_props.sv
dv/mem_read_tb.sv

// ==== Makefile ====
TOP := mem_read_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== dv/mem_read_tb.sv ====
// In-order AXI slave model; ids 1 and 2 are reserved, data cache ids run from 3 to 15
module mem_read_tb import mem_arb_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int      REQS_PER_PORT  = 12;
  localparam int      TIMEOUT_CYCLES = 20000;
  localparam mem_id_t IC_ID          = 4'd1;
  localparam mem_id_t UC_ID          = 4'd2;

  logic         clk_i = 1'b0;
  logic         reset_i;
  logic         icache_miss_valid_i;
  logic         icache_miss_ready_o;
  mem_addr_t    icache_miss_paddr_i;
  mem_id_t      icache_miss_id_i;
  logic         icache_refill_valid_o;
  icache_line_t icache_refill_data_o;
  mem_id_t      icache_refill_id_o;
  logic         dcache_miss_valid_i;
  logic         dcache_miss_ready_o;
  mem_req_t     dcache_miss_i;
  logic         dcache_miss_resp_valid_o;
  logic         dcache_miss_resp_ready_i;
  mem_resp_r_t  dcache_miss_resp_o;
  logic         uc_read_valid_i;
  logic         uc_read_ready_o;
  mem_req_t     uc_read_i;
  mem_id_t      uc_read_id_i;
  logic         uc_read_resp_valid_o;
  logic         uc_read_resp_ready_i;
  mem_resp_r_t  uc_read_resp_o;
  logic         axi_ar_valid_o;
  logic         axi_ar_ready_i;
  axi_ar_t      axi_ar_o;
  logic         axi_r_valid_i;
  logic         axi_r_ready_o;
  axi_r_t       axi_r_i;

  integer      seed = 32'ha61ca4d3;
  logic [2:0]  req_fire;
  logic        r_fire;
  int unsigned issued [3];
  int unsigned done_cnt;
  int unsigned reset_cycles;
  int unsigned cycles;
  int          beat;
  axi_ar_t     ar_q [$];

  mem_read_subsystem mem_read_subsystem_i (.*);

  initial begin
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // Handshakes and completions, sampled like a flop
  always @(posedge clk_i) begin
    req_fire[0] <= icache_miss_valid_i & icache_miss_ready_o;
    req_fire[1] <= dcache_miss_valid_i & dcache_miss_ready_o;
    req_fire[2] <= uc_read_valid_i & uc_read_ready_o;
    r_fire      <= axi_r_valid_i & axi_r_ready_o;
    if (axi_ar_valid_o && axi_ar_ready_i) begin
      ar_q.push_back(axi_ar_o);
    end
    if (icache_refill_valid_o) begin
      done_cnt++;
    end
    if (axi_r_valid_i && axi_r_ready_o && axi_r_i.last && axi_r_i.id != IC_ID) begin
      done_cnt++;
    end
  end

  // Each port raises a new request at random and holds it until accepted
  task automatic drive_requests();
    integer r;
    integer a;
    r = $random(seed);
    a = $random(seed);
    if (req_fire[0]) begin
      icache_miss_valid_i = 1'b0;
      issued[0]++;
    end else if (!icache_miss_valid_i && issued[0] < REQS_PER_PORT && r[1:0] == 2'd0) begin
      icache_miss_valid_i = 1'b1;
      icache_miss_paddr_i = {a[31:4], 4'h0};
    end
    if (req_fire[1]) begin
      dcache_miss_valid_i = 1'b0;
      issued[1]++;
    end else if (!dcache_miss_valid_i && issued[1] < REQS_PER_PORT && r[3:2] == 2'd0) begin
      dcache_miss_valid_i = 1'b1;
      dcache_miss_i = '{addr: {a[31:5], 5'h0}, len: mem_len_t'(a[1:0]), size: 3'd3,
                        id: mem_id_t'(3 + issued[1] % 13), cacheable: 1'b1};
    end
    if (req_fire[2]) begin
      uc_read_valid_i = 1'b0;
      issued[2]++;
    end else if (!uc_read_valid_i && issued[2] < REQS_PER_PORT && r[5:4] == 2'd0) begin
      uc_read_valid_i = 1'b1;
      uc_read_i = '{addr: {a[31:3], 3'h0}, len: 8'd0, size: 3'd3, id: UC_ID, cacheable: 1'b0};
    end
  endtask

  // AXI slave with random stalls; beats carry address plus beat index
  task automatic drive_memory();
    integer r;
    r = $random(seed);
    axi_ar_ready_i           = (r[1:0] != 2'd0);
    dcache_miss_resp_ready_i = (r[3:2] != 2'd0);
    uc_read_resp_ready_i     = (r[5:4] != 2'd0);
    if (r_fire) begin
      if (axi_r_i.last) begin
        ar_q.delete(0);
        beat = 0;
      end else begin
        beat++;
      end
      axi_r_valid_i = 1'b0;
    end
    if (!axi_r_valid_i && ar_q.size() != 0 && r[7:6] != 2'd0) begin
      axi_r_valid_i = 1'b1;
      axi_r_i = '{id: ar_q[0].id, data: mem_data_t'(ar_q[0].addr) + mem_data_t'(beat),
                  last: (beat == int'(ar_q[0].len))};
    end
  endtask

  always @(negedge clk_i) begin
    if (reset_cycles < 16) begin
      reset_cycles++;
      reset_i = (reset_cycles < 16);
    end else begin
      drive_requests();
      drive_memory();
    end
  end

  always @(negedge clk_i) begin
    if (mem_read_subsystem_i.mem_read_props_i.fail_count != 0) begin
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first assertion failure");
    end
  end

  initial begin
    reset_i                  = 1'b1;
    icache_miss_valid_i      = 1'b0;
    icache_miss_paddr_i      = '0;
    icache_miss_id_i         = IC_ID;
    dcache_miss_valid_i      = 1'b0;
    dcache_miss_i            = '0;
    dcache_miss_resp_ready_i = 1'b0;
    uc_read_valid_i          = 1'b0;
    uc_read_i                = '0;
    uc_read_id_i             = UC_ID;
    uc_read_resp_ready_i     = 1'b0;
    axi_ar_ready_i           = 1'b0;
    axi_r_valid_i            = 1'b0;
    axi_r_i                  = '0;
    for (int p = 0; p < 3; p++) begin
      issued[p] = 0;
    end
    done_cnt     = 0;
    reset_cycles = 0;
    cycles       = 0;
    beat         = 0;
    while (done_cnt < 3 * REQS_PER_PORT && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (done_cnt < 3 * REQS_PER_PORT) begin
      $display("Timeout after %0d cycles with %0d of %0d requests completed",
               cycles, done_cnt, 3 * REQS_PER_PORT);
      $display("FAIL: see errors above");
      $fatal(1, "Run stopped on timeout");
    end else if (mem_read_subsystem_i.mem_read_props_i.fail_count != 0) begin
      $display("FAIL: see errors above");
      $fatal(1, "Run ended with assertion failures");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== dv/mem_read_props.sv ====
// Line checks assume two beats per line and an AXI slave that never interleaves bursts
module mem_read_props import mem_arb_pkg::*; (
  input logic         clk_i,
  input logic         reset_i,
  input logic         icache_miss_valid_i,
  input logic         icache_miss_ready_o,
  input mem_id_t      icache_miss_id_i,
  input mem_id_t      uc_read_id_i,
  input logic         icache_refill_valid_o,
  input icache_line_t icache_refill_data_o,
  input mem_id_t      icache_refill_id_o,
  input logic         dcache_miss_valid_i,
  input logic         dcache_miss_ready_o,
  input logic         dcache_miss_resp_valid_o,
  input logic         dcache_miss_resp_ready_i,
  input mem_resp_r_t  dcache_miss_resp_o,
  input logic         uc_read_valid_i,
  input logic         uc_read_ready_o,
  input logic         uc_read_resp_valid_o,
  input logic         uc_read_resp_ready_i,
  input mem_resp_r_t  uc_read_resp_o,
  input logic         axi_ar_valid_o,
  input logic         axi_ar_ready_i,
  input axi_ar_t      axi_ar_o,
  input logic         axi_r_valid_i,
  input logic         axi_r_ready_o,
  input axi_r_t       axi_r_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  logic         quiet;
  logic         r_fire;
  logic         r_to_ic;
  logic         r_to_uc;
  mem_resp_r_t  r_exp;
  logic         ar_stall_q;
  axi_ar_t      ar_q;
  logic         line_done_q;
  mem_data_t    prev_data_q;
  icache_line_t line_q;
  int unsigned  ic_wait_q;
  int unsigned  dc_wait_q;
  int unsigned  uc_wait_q;

  assign quiet = ~axi_ar_valid_o & ~icache_refill_valid_o &
                 ~dcache_miss_resp_valid_o & ~uc_read_resp_valid_o;
  assign r_fire  = axi_r_valid_i & axi_r_ready_o;
  assign r_to_ic = (axi_r_i.id == icache_miss_id_i);
  assign r_to_uc = ~r_to_ic & (axi_r_i.id == uc_read_id_i);

  // Routed beat must carry the R beat unchanged
  always_comb begin
    r_exp.data = axi_r_i.data;
    r_exp.id   = axi_r_i.id;
    r_exp.last = axi_r_i.last;
  end

  // History for stability, line and fairness checks
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ar_stall_q  <= 1'b0;
      line_done_q <= 1'b0;
      ic_wait_q   <= 0;
      dc_wait_q   <= 0;
      uc_wait_q   <= 0;
    end else begin
      ar_stall_q  <= axi_ar_valid_o & ~axi_ar_ready_i;
      line_done_q <= r_fire & r_to_ic & axi_r_i.last;
      ic_wait_q   <= (icache_miss_valid_i && !icache_miss_ready_o && axi_ar_ready_i) ?
                     ic_wait_q + 1 : 0;
      dc_wait_q   <= (dcache_miss_valid_i && !dcache_miss_ready_o && axi_ar_ready_i) ?
                     dc_wait_q + 1 : 0;
      uc_wait_q   <= (uc_read_valid_i && !uc_read_ready_o && axi_ar_ready_i) ?
                     uc_wait_q + 1 : 0;
    end
  end

  // Expected line is the last beat above the one before it
  always_ff @(posedge clk_i) begin
    ar_q <= axi_ar_o;
    if (r_fire && r_to_ic) begin
      prev_data_q <= axi_r_i.data;
      line_q      <= {axi_r_i.data, prev_data_q};
    end
  end

  a_reset_quiet: assert property (@(posedge clk_i) (reset_i || $past(reset_i)) |-> quiet)
    else begin
      fail_count++;
      $error("An output valid was high during reset or in the cycle after it");
    end

  a_ar_held: assert property (@(posedge clk_i) ar_stall_q |-> axi_ar_valid_o)
    else begin
      fail_count++;
      $error("axi_ar_valid_o dropped before the AR transfer was accepted");
    end

  a_ar_stable: assert property (@(posedge clk_i) ar_stall_q |-> axi_ar_o == ar_q)
    else begin
      fail_count++;
      $error("[FAIL] %0t axi_ar_o exp %h got %h", $time, $sampled(ar_q), $sampled(axi_ar_o));
    end

  a_ic_burst: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_ar_valid_o && axi_ar_o.id == icache_miss_id_i |->
      axi_ar_o.len == mem_len_t'(ICACHE_BEATS - 1) &&
      axi_ar_o.size == mem_size_t'(ICACHE_BEAT_SIZE) && axi_ar_o.cacheable)
    else begin
      fail_count++;
      $error("[FAIL] %0t axi_ar_o len/size/cacheable exp %0d/%0d/1 got %0d/%0d/%0d", $time,
             ICACHE_BEATS - 1, ICACHE_BEAT_SIZE, $sampled(axi_ar_o.len),
             $sampled(axi_ar_o.size), $sampled(axi_ar_o.cacheable));
    end

  a_line_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      icache_refill_valid_o == line_done_q)
    else begin
      fail_count++;
      $error("[FAIL] %0t icache_refill_valid_o exp %0b got %0b", $time,
             $sampled(line_done_q), $sampled(icache_refill_valid_o));
    end

  a_line_data: assert property (@(posedge clk_i) disable iff (reset_i)
      line_done_q |-> icache_refill_data_o == line_q && icache_refill_id_o == icache_miss_id_i)
    else begin
      fail_count++;
      $error("[FAIL] %0t icache_refill_data_o/id exp %h/%0d got %h/%0d", $time,
             $sampled(line_q), $sampled(icache_miss_id_i),
             $sampled(icache_refill_data_o), $sampled(icache_refill_id_o));
    end

  a_uc_route: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_r_valid_i && r_to_uc |-> uc_read_resp_valid_o && !dcache_miss_resp_valid_o)
    else begin
      fail_count++;
      $error("An uncached R beat was not routed to the uncached port alone");
    end

  a_dc_route: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_r_valid_i && !r_to_ic && !r_to_uc |-> dcache_miss_resp_valid_o && !uc_read_resp_valid_o)
    else begin
      fail_count++;
      $error("A data cache R beat was not routed to the data cache port alone");
    end

  a_resp_data: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_r_valid_i && !r_to_ic |->
      (r_to_uc ? uc_read_resp_o : dcache_miss_resp_o) == r_exp)
    else begin
      fail_count++;
      $error("[FAIL] %0t resp exp %h got %h", $time, $sampled(r_exp),
             $sampled(r_to_uc ? uc_read_resp_o : dcache_miss_resp_o));
    end

  a_r_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_r_valid_i && !r_to_ic |->
      axi_r_ready_o == (r_to_uc ? uc_read_resp_ready_i : dcache_miss_resp_ready_i))
    else begin
      fail_count++;
      $error("[FAIL] %0t axi_r_ready_o exp %0b got %0b", $time,
             $sampled(r_to_uc ? uc_read_resp_ready_i : dcache_miss_resp_ready_i),
             $sampled(axi_r_ready_o));
    end

  a_ic_accept: assert property (@(posedge clk_i) disable iff (reset_i) ic_wait_q < 4)
    else begin
      fail_count++;
      $error("An instruction miss request waited more than four cycles to be accepted");
    end

  a_dc_fair: assert property (@(posedge clk_i) disable iff (reset_i) dc_wait_q < 4)
    else begin
      fail_count++;
      $error("A data cache miss request waited more than four cycles for its grant");
    end

  a_uc_fair: assert property (@(posedge clk_i) disable iff (reset_i) uc_wait_q < 4)
    else begin
      fail_count++;
      $error("An uncached read request waited more than four cycles for its grant");
    end

endmodule

bind mem_read_subsystem mem_read_props mem_read_props_i (.*);

// ==== source/mem_read_subsystem.sv ====
// Read path only; responses route by id, so data cache ids must differ from both fixed ids
`include "mem_arb_config.svh"

module mem_read_subsystem import mem_arb_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,

  // Instruction cache
  input  logic         icache_miss_valid_i,
  output logic         icache_miss_ready_o,
  input  mem_addr_t    icache_miss_paddr_i,
  input  mem_id_t      icache_miss_id_i,
  output logic         icache_refill_valid_o,
  output icache_line_t icache_refill_data_o,
  output mem_id_t      icache_refill_id_o,

  // Data cache miss
  input  logic         dcache_miss_valid_i,
  output logic         dcache_miss_ready_o,
  input  mem_req_t     dcache_miss_i,
  output logic         dcache_miss_resp_valid_o,
  input  logic         dcache_miss_resp_ready_i,
  output mem_resp_r_t  dcache_miss_resp_o,

  // Uncached read
  input  logic         uc_read_valid_i,
  output logic         uc_read_ready_o,
  input  mem_req_t     uc_read_i,
  input  mem_id_t      uc_read_id_i,
  output logic         uc_read_resp_valid_o,
  input  logic         uc_read_resp_ready_i,
  output mem_resp_r_t  uc_read_resp_o,

  // AXI read channels
  output logic         axi_ar_valid_o,
  input  logic         axi_ar_ready_i,
  output axi_ar_t      axi_ar_o,
  input  logic         axi_r_valid_i,
  output logic         axi_r_ready_o,
  input  axi_r_t       axi_r_i
);

  mem_req_t                     icache_req;
  logic [`N_READ_PORTS-1:0]     rd_valid;
  logic [`N_READ_PORTS-1:0]     rd_ready;
  mem_req_t [`N_READ_PORTS-1:0] rd_req;
  logic                         arb_valid;
  logic                         arb_ready;
  mem_req_t                     arb_req;
  logic                         resp_valid;
  logic                         resp_ready;
  mem_resp_r_t                  resp;
  mem_resp_r_t                  resp_routed;
  logic                         refill_beat_valid;

  // Full-line burst for an instruction miss
  assign icache_req = '{
    addr:      icache_miss_paddr_i,
    len:       mem_len_t'(ICACHE_BEATS - 1),
    size:      mem_size_t'(ICACHE_BEAT_SIZE),
    id:        icache_miss_id_i,
    cacheable: 1'b1
  };

  // Keeps the miss stable if the icache withdraws it
  mem_fifo_reg #(
    .payload_t (mem_req_t)
  ) i_icache_req_reg (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wr_valid_i (icache_miss_valid_i),
    .wr_ready_o (icache_miss_ready_o),
    .wr_data_i  (icache_req),
    .rd_valid_o (rd_valid[0]),
    .rd_ready_i (rd_ready[0]),
    .rd_data_o  (rd_req[0])
  );

  assign rd_valid[1]         = dcache_miss_valid_i;
  assign rd_req[1]           = dcache_miss_i;
  assign dcache_miss_ready_o = rd_ready[1];

  assign rd_valid[2]     = uc_read_valid_i;
  assign rd_req[2]       = uc_read_i;
  assign uc_read_ready_o = rd_ready[2];

  mem_read_arbiter i_read_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (rd_valid),
    .req_ready_o (rd_ready),
    .req_i       (rd_req),
    .arb_valid_o (arb_valid),
    .arb_ready_i (arb_ready),
    .arb_req_o   (arb_req)
  );

  mem_to_axi_read i_to_axi_read (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_valid_i    (arb_valid),
    .req_ready_o    (arb_ready),
    .req_i          (arb_req),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_ar_o       (axi_ar_o),
    .axi_r_valid_i  (axi_r_valid_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .axi_r_i        (axi_r_i),
    .resp_valid_o   (resp_valid),
    .resp_ready_i   (resp_ready),
    .resp_o         (resp)
  );

  mem_resp_demux i_resp_demux (
    .resp_valid_i   (resp_valid),
    .resp_ready_o   (resp_ready),
    .resp_i         (resp),
    .icache_id_i    (icache_miss_id_i),
    .uc_read_id_i   (uc_read_id_i),
    .icache_valid_o (refill_beat_valid),
    .dcache_valid_o (dcache_miss_resp_valid_o),
    .dcache_ready_i (dcache_miss_resp_ready_i),
    .uc_valid_o     (uc_read_resp_valid_o),
    .uc_ready_i     (uc_read_resp_ready_i),
    .resp_o         (resp_routed)
  );

  assign dcache_miss_resp_o = resp_routed;
  assign uc_read_resp_o     = resp_routed;

  icache_line_upsize i_line_upsize (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .beat_valid_i (refill_beat_valid),
    .beat_i       (resp_routed),
    .line_valid_o (icache_refill_valid_o),
    .line_o       (icache_refill_data_o),
    .line_id_o    (icache_refill_id_o)
  );

endmodule

// ==== source/mem_to_axi_read.sv ====
// No response error or user signals; the R path is combinational and the AR path registered
module mem_to_axi_read import mem_arb_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  mem_req_t    req_i,

  output logic        axi_ar_valid_o,
  input  logic        axi_ar_ready_i,
  output axi_ar_t     axi_ar_o,

  input  logic        axi_r_valid_i,
  output logic        axi_r_ready_o,
  input  axi_r_t      axi_r_i,

  output logic        resp_valid_o,
  input  logic        resp_ready_i,
  output mem_resp_r_t resp_o
);

  axi_ar_t ar_wdata;

  // Request fields in AR order
  assign ar_wdata = '{
    id:        req_i.id,
    addr:      req_i.addr,
    len:       req_i.len,
    size:      req_i.size,
    cacheable: req_i.cacheable
  };

  // AR stage holds the channel stable under AR back-pressure
  mem_fifo_reg #(
    .payload_t (axi_ar_t)
  ) i_ar_reg (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .wr_valid_i (req_valid_i),
    .wr_ready_o (req_ready_o),
    .wr_data_i  (ar_wdata),
    .rd_valid_o (axi_ar_valid_o),
    .rd_ready_i (axi_ar_ready_i),
    .rd_data_o  (axi_ar_o)
  );

  assign resp_valid_o  = axi_r_valid_i;
  assign axi_r_ready_o = resp_ready_i;
  assign resp_o        = '{data: axi_r_i.data, id: axi_r_i.id, last: axi_r_i.last};

endmodule

// ==== source/mem_resp_demux.sv ====
// Purely combinational; if both configured ids are equal the instruction port takes the beat
module mem_resp_demux import mem_arb_pkg::*; (
  input  logic        resp_valid_i,
  output logic        resp_ready_o,
  input  mem_resp_r_t resp_i,

  input  mem_id_t     icache_id_i,
  input  mem_id_t     uc_read_id_i,

  output logic        icache_valid_o,

  output logic        dcache_valid_o,
  input  logic        dcache_ready_i,

  output logic        uc_valid_o,
  input  logic        uc_ready_i,

  output mem_resp_r_t resp_o
);

  logic to_icache;
  logic to_uc;
  logic to_dcache;

  // Destination decode from the beat id
  assign to_icache = (resp_i.id == icache_id_i);
  assign to_uc     = ~to_icache && (resp_i.id == uc_read_id_i);
  assign to_dcache = ~to_icache && ~to_uc;

  assign icache_valid_o = resp_valid_i & to_icache;
  assign uc_valid_o     = resp_valid_i & to_uc;
  assign dcache_valid_o = resp_valid_i & to_dcache;

  // Upsizer never back-pressures
  always_comb begin
    if (to_icache) begin
      resp_ready_o = 1'b1;
    end else if (to_uc) begin
      resp_ready_o = uc_ready_i;
    end else begin
      resp_ready_o = dcache_ready_i;
    end
  end

  // Payload is shared, only the valids select
  assign resp_o = resp_i;

endmodule

// ==== source/mem_read_arbiter.sv ====
// Requesters must keep valid and payload stable until ready, or a held grant stalls the bus
`include "mem_arb_config.svh"

module mem_read_arbiter import mem_arb_pkg::*; (
  input  logic                         clk_i,
  input  logic                         reset_i,

  input  logic [`N_READ_PORTS-1:0]     req_valid_i,
  output logic [`N_READ_PORTS-1:0]     req_ready_o,
  input  mem_req_t [`N_READ_PORTS-1:0] req_i,

  output logic                         arb_valid_o,
  input  logic                         arb_ready_i,
  output mem_req_t                     arb_req_o
);

  localparam int N     = `N_READ_PORTS;
  localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

  typedef logic [IDX_W-1:0] port_idx_t;

  port_idx_t last_q;
  port_idx_t gnt_q;
  logic      hold_q;
  port_idx_t pick;
  port_idx_t sel;

  // First valid port after the last winner
  always_comb begin
    int   idx;
    logic found;
    pick  = last_q;
    found = 1'b0;
    for (int k = 1; k <= N; k++) begin
      idx = (int'(last_q) + k) % N;
      if (!found && req_valid_i[idx]) begin
        pick  = port_idx_t'(idx);
        found = 1'b1;
      end
    end
  end

  // A stalled grant stays on the same port
  assign sel         = hold_q ? gnt_q : pick;
  assign arb_valid_o = req_valid_i[sel];
  assign arb_req_o   = req_i[sel];

  always_comb begin
    for (int i = 0; i < N; i++) begin
      req_ready_o[i] = arb_valid_o && arb_ready_i && (sel == port_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= port_idx_t'(N - 1);
      gnt_q  <= '0;
      hold_q <= 1'b0;
    end else if (arb_valid_o) begin
      if (arb_ready_i) begin
        last_q <= sel;
        hold_q <= 1'b0;
      end else begin
        gnt_q  <= sel;
        hold_q <= 1'b1;
      end
    end
  end

endmodule

// ==== source/icache_line_upsize.sv ====
// Always accepts beats; a line is assumed to arrive as ICACHE_BEATS beats ending with last
module icache_line_upsize import mem_arb_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,

  input  logic         beat_valid_i,
  input  mem_resp_r_t  beat_i,

  output logic         line_valid_o,
  output icache_line_t line_o,
  output mem_id_t      line_id_o
);

  localparam int SLOT_W = (ICACHE_BEATS > 1) ? $clog2(ICACHE_BEATS) : 1;

  logic [SLOT_W-1:0]              slot_q;
  mem_data_t [ICACHE_BEATS-1:0]   beats_q;
  mem_id_t                        id_q;
  logic                           valid_q;

  // Slot counter and refill pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= beat_valid_i & beat_i.last;
      if (beat_valid_i) begin
        if (beat_i.last) begin
          slot_q <= '0;
        end else begin
          slot_q <= slot_q + 1'b1;
        end
      end
    end
  end

  // Low half is filled first
  always_ff @(posedge clk_i) begin
    if (beat_valid_i) begin
      beats_q[slot_q] <= beat_i.data;
      if (beat_i.last) begin
        id_q <= beat_i.id;
      end
    end
  end

  // Next line may start overwriting in the pulse cycle, visible only afterwards
  assign line_valid_o = valid_q;
  assign line_o       = icache_line_t'(beats_q);
  assign line_id_o    = id_q;

endmodule

// ==== source/mem_fifo_reg.sv ====
// Single entry only; wr_ready_o depends combinationally on rd_ready_i when the entry is full
module mem_fifo_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     wr_valid_i,
  output logic     wr_ready_o,
  input  payload_t wr_data_i,

  output logic     rd_valid_o,
  input  logic     rd_ready_i,
  output payload_t rd_data_o
);

  logic     full_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign wr_ready_o = ~full_q | rd_ready_i;
  assign rd_valid_o = full_q;
  assign rd_data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (wr_valid_i && wr_ready_o) begin
      full_q <= 1'b1;
    end else if (rd_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload only moves on a write handshake
  always_ff @(posedge clk_i) begin
    if (wr_valid_i && wr_ready_o) begin
      data_q <= wr_data_i;
    end
  end

endmodule

// ==== source/mem_arb_pkg.sv ====
// Types assume AXI4 burst lengths (8-bit len) and byte-sized beats no wider than 128 bytes
`include "mem_arb_config.svh"

package mem_arb_pkg;

  // Refill beats per instruction line and log2 of bytes per beat
  localparam int ICACHE_BEATS     = `ICACHE_LINE_WIDTH / `MEM_DATA_WIDTH;
  localparam int ICACHE_BEAT_SIZE = $clog2(`MEM_DATA_WIDTH / 8);

  typedef logic [`MEM_ID_WIDTH-1:0]      mem_id_t;
  typedef logic [`MEM_ADDR_WIDTH-1:0]    mem_addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0]    mem_data_t;
  typedef logic [7:0]                    mem_len_t;
  typedef logic [2:0]                    mem_size_t;
  typedef logic [`ICACHE_LINE_WIDTH-1:0] icache_line_t;

  // Read request from a cache port
  typedef struct packed {
    mem_addr_t addr;
    mem_len_t  len;
    mem_size_t size;
    mem_id_t   id;
    logic      cacheable;
  } mem_req_t;

  // One read response beat towards a cache port
  typedef struct packed {
    mem_data_t data;
    mem_id_t   id;
    logic      last;
  } mem_resp_r_t;

  // AR channel payload
  typedef struct packed {
    mem_id_t   id;
    mem_addr_t addr;
    mem_len_t  len;
    mem_size_t size;
    logic      cacheable;
  } axi_ar_t;

  // R channel payload
  typedef struct packed {
    mem_id_t   id;
    mem_data_t data;
    logic      last;
  } axi_r_t;

endpackage

// ==== include/mem_arb_config.svh ====
// Line width must be a whole multiple of the data width, and the data width no wider than a line
`ifndef MEM_ARB_CONFIG_SVH
`define MEM_ARB_CONFIG_SVH

// AXI read data bus width in bits
`define MEM_DATA_WIDTH 64

// Instruction cache refill line width in bits
`define ICACHE_LINE_WIDTH 128

// Physical address width
`define MEM_ADDR_WIDTH 32

// Transaction id width, shared by all requesters
`define MEM_ID_WIDTH 4

// Read requesters: icache miss, dcache miss, dcache uncached read
`define N_READ_PORTS 3

`endif
